//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_read
FLIST     ?= sources.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run test clean

all: test

build: $(SIM_BIN)

# rebuilt only when the file list or one of its sources changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

test: run
	@if grep -q "All tests passed!" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/adc_channel_shifter.sv
`timescale 1ns/1ps

module adc_channel_shifter
    import adc_read_pkg::*;
#(
    parameter int SAMPLE_WIDTH = SAMPLE_WIDTH_DEF
)
(
    input  logic                    lclk_arpel_in,
    input  logic                    lrst_arpel_in,
    input  logic                    sdain,
    input  logic                    shift,
    input  logic                    publish,
    output logic [SAMPLE_WIDTH-1:0] word
);

    logic [SAMPLE_WIDTH-1:0] shift_reg;

    // --------------------
    // serial capture
    // --------------------
    // msb arrives first, so it ends up at the top after the last bit
    always_ff @(posedge lclk_arpel_in)
    begin
        if (lrst_arpel_in)
        begin
            shift_reg <= '0;
        end
        else if (shift)
        begin
            shift_reg <= {shift_reg[SAMPLE_WIDTH-2:0], sdain};
        end
    end

    // --------------------
    // held output word
    // --------------------
    // stays stable while the next word is shifted in
    always_ff @(posedge lclk_arpel_in)
    begin
        if (lrst_arpel_in)
        begin
            word <= '0;
        end
        else if (publish)
        begin
            word <= shift_reg;
        end
    end

endmodule

//--- rtl/adc_conv_sequencer.sv
`timescale 1ns/1ps

module adc_conv_sequencer
    import adc_read_pkg::*;
#(
    parameter int SAMPLE_WIDTH  = SAMPLE_WIDTH_DEF,
    parameter int CONVST_CYCLES = CONVST_CYCLES_DEF
)
(
    input  logic      lclk_arpel_in,
    input  logic      lrst_arpel_in,
    input  logic      adc_enable,
    input  logic      busy,
    output adc_pins_t pins,
    output logic      shift_ch1,
    output logic      shift_ch2,
    output logic      publish
);

    localparam int CONV_W = $clog2(CONVST_CYCLES + 1);
    localparam int BIT_W  = $clog2(SAMPLE_WIDTH + 1);

    localparam logic [CONV_W-1:0] CONV_LAST = CONV_W'(CONVST_CYCLES - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(SAMPLE_WIDTH - 1);

    adc_state_e        state;
    adc_state_e        state_next;
    logic [CONV_W-1:0] conv_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic              sclk_phase;
    logic              in_read;
    logic              bit_last;
    logic              cs_active;

    // phase 0 is the sclk low half, phase 1 the high half
    assign in_read  = (state == ST_READ_CH1) || (state == ST_READ_CH2);
    assign bit_last = sclk_phase && (bit_cnt == BIT_LAST);

    // chip select held low from cs fall through both read windows
    assign cs_active = state inside {ST_CS_FALL, ST_CONVST, ST_BUSY_WAIT,
                                     ST_BUSY_HIGH, ST_READ_CH1, ST_READ_CH2};

    // --------------------
    // next state
    // --------------------
    always_comb
    begin
        state_next = state;
        case (state)
            ST_RESET:
                state_next = ST_IDLE;
            ST_IDLE:
                if (adc_enable)
                    state_next = ST_CS_FALL;
            ST_CS_FALL:
                state_next = ST_CONVST;
            ST_CONVST:
                if (conv_cnt == CONV_LAST)
                    state_next = ST_BUSY_WAIT;
            ST_BUSY_WAIT:
                state_next = ST_BUSY_HIGH;
            // conversion running until busy drops
            ST_BUSY_HIGH:
                if (!busy)
                    state_next = ST_READ_CH1;
            ST_READ_CH1:
                if (bit_last)
                    state_next = ST_CH_GAP;
            ST_CH_GAP:
                state_next = ST_READ_CH2;
            ST_READ_CH2:
                if (bit_last)
                    state_next = ST_CS_RISE;
            ST_CS_RISE:
                state_next = ST_DONE;
            ST_DONE:
                state_next = ST_IDLE;
            default:
                state_next = ST_RESET;
        endcase
    end

    // --------------------
    // state and counters
    // --------------------
    always_ff @(posedge lclk_arpel_in)
    begin
        if (lrst_arpel_in)
        begin
            state      <= ST_RESET;
            conv_cnt   <= '0;
            bit_cnt    <= '0;
            sclk_phase <= 1'b0;
        end
        else
        begin
            state <= state_next;

            if (state == ST_CONVST)
                conv_cnt <= conv_cnt + 1'b1;
            else
                conv_cnt <= '0;

            // bit count advances after each high half
            if (in_read && !bit_last)
            begin
                sclk_phase <= ~sclk_phase;
                bit_cnt    <= bit_cnt + BIT_W'(sclk_phase);
            end
            else
            begin
                sclk_phase <= 1'b0;
                bit_cnt    <= '0;
            end
        end
    end

    // --------------------
    // registered outputs
    // --------------------
    // each output follows the state by one cycle
    always_ff @(posedge lclk_arpel_in)
    begin
        if (lrst_arpel_in)
        begin
            pins      <= '{cs_n: 1'b1, convst_n: 1'b1, sclk: 1'b1};
            shift_ch1 <= 1'b0;
            shift_ch2 <= 1'b0;
            publish   <= 1'b0;
        end
        else
        begin
            pins.cs_n     <= !cs_active;
            pins.convst_n <= (state != ST_CONVST);
            pins.sclk     <= !(in_read && !sclk_phase);
            // strobe lines up with sclk low, data sampled on its rising edge
            shift_ch1     <= (state == ST_READ_CH1) && !sclk_phase;
            shift_ch2     <= (state == ST_READ_CH2) && !sclk_phase;
            publish       <= (state == ST_DONE);
        end
    end

endmodule

//--- rtl/adc_read_pkg.sv
package adc_read_pkg;

    // --------------------
    // default sizes
    // --------------------

    // bits per channel word
    localparam int SAMPLE_WIDTH_DEF = 16;

    // convert-start low time in clock cycles
    localparam int CONVST_CYCLES_DEF = 16;

    // --------------------
    // sequencer states
    // --------------------

    typedef enum logic [3:0] {
        ST_RESET,
        ST_IDLE,
        ST_CS_FALL,
        ST_CONVST,
        ST_BUSY_WAIT,
        ST_BUSY_HIGH,
        ST_READ_CH1,
        ST_CH_GAP,
        ST_READ_CH2,
        ST_CS_RISE,
        ST_DONE
    } adc_state_e;

    // --------------------
    // pin and sample bundles
    // --------------------

    // all three are active low or idle high
    typedef struct packed {
        logic cs_n;
        logic convst_n;
        logic sclk;
    } adc_pins_t;

    typedef struct packed {
        logic [SAMPLE_WIDTH_DEF-1:0] ch1;
        logic [SAMPLE_WIDTH_DEF-1:0] ch2;
    } adc_sample_t;

endpackage

//--- rtl/adc_read_top.sv
`timescale 1ns/1ps

module adc_read_top
    import adc_read_pkg::*;
#(
    parameter int SAMPLE_WIDTH  = SAMPLE_WIDTH_DEF,
    parameter int CONVST_CYCLES = CONVST_CYCLES_DEF
)
(
    input  logic        lclk_arpel_in,
    input  logic        lrst_arpel_in,
    input  logic        adc_enable,
    input  logic        busy,
    input  logic        sdain,
    output adc_pins_t   pins,
    output adc_sample_t samples,
    output logic        done
);

    logic                    shift_ch1;
    logic                    shift_ch2;
    logic                    publish;
    logic [SAMPLE_WIDTH-1:0] ch1_word;
    logic [SAMPLE_WIDTH-1:0] ch2_word;

    // --------------------
    // control
    // --------------------
    adc_conv_sequencer #(
        .SAMPLE_WIDTH  (SAMPLE_WIDTH),
        .CONVST_CYCLES (CONVST_CYCLES)
    ) u_seq (
        .lclk_arpel_in (lclk_arpel_in),
        .lrst_arpel_in (lrst_arpel_in),
        .adc_enable    (adc_enable),
        .busy          (busy),
        .pins          (pins),
        .shift_ch1     (shift_ch1),
        .shift_ch2     (shift_ch2),
        .publish       (publish)
    );

    // --------------------
    // channel data
    // --------------------
    // both shifters share the one serial line, filled one after the other
    adc_channel_shifter #(
        .SAMPLE_WIDTH  (SAMPLE_WIDTH)
    ) u_ch1 (
        .lclk_arpel_in (lclk_arpel_in),
        .lrst_arpel_in (lrst_arpel_in),
        .sdain         (sdain),
        .shift         (shift_ch1),
        .publish       (publish),
        .word          (ch1_word)
    );

    adc_channel_shifter #(
        .SAMPLE_WIDTH  (SAMPLE_WIDTH)
    ) u_ch2 (
        .lclk_arpel_in (lclk_arpel_in),
        .lrst_arpel_in (lrst_arpel_in),
        .sdain         (sdain),
        .shift         (shift_ch2),
        .publish       (publish),
        .word          (ch2_word)
    );

    // samples take the new pair on the edge that ends the done pulse
    assign samples = '{ch1: ch1_word, ch2: ch2_word};
    assign done    = publish;

endmodule

//--- sources.f
rtl/adc_read_pkg.sv
rtl/adc_conv_sequencer.sv
rtl/adc_channel_shifter.sv
rtl/adc_read_top.sv
test/adc_serial_model.sv
test/tb_adc_read.sv

//--- test/adc_read_tests.txt
# gap busy ch1 ch2
# gap and busy in clock cycles (decimal), channel words in hex
2 4 1234 abcd
0 1 0000 ffff
3 8 ffff 0000
0 2 aaaa 5555
1 1 5555 aaaa
5 12 8000 0001
0 3 0001 8000
4 20 7fff fffe
1 6 c3a5 5a3c
0 1 dead beef
2 9 0f0f f0f0
6 2 1357 2468
0 5 fedc ba98
3 1 4c1d 93e7
1 15 0102 0304
7 3 ffff ffff

//--- test/adc_serial_model.sv
`timescale 1ns/1ps

module adc_serial_model
    import adc_read_pkg::*;
#(
    parameter int DRIVE_DELAY = 2
)
(
    input  logic        lclk_arpel_in,
    input  logic        lrst_arpel_in,
    input  adc_pins_t   pins,
    input  adc_sample_t words,
    input  int          busy_cycles,
    output logic        busy,
    output logic        sdain
);

    logic [SAMPLE_WIDTH_DEF-1:0] shift_word = '0;
    adc_pins_t                   prev_pins  = '1;
    logic                        busy_q     = 1'b0;
    logic                        sdain_q    = 1'b0;
    logic                        second     = 1'b0;
    int                          remaining  = 0;

    assign busy  = busy_q;
    assign sdain = sdain_q;

    // pins are looked at a short delay after each rising edge, once they have settled
    always @(posedge lclk_arpel_in)
    begin
        logic in_reset;
        in_reset = lrst_arpel_in;
        #(DRIVE_DELAY);
        if (in_reset)
        begin
            busy_q    = 1'b0;
            sdain_q   = 1'b0;
            second    = 1'b0;
            remaining = 0;
        end
        else
        begin
            // --------------------
            // conversion time
            // --------------------
            if (remaining > 0)
            begin
                remaining = remaining - 1;
                if (remaining == 0)
                    busy_q = 1'b0;
            end
            if (pins.convst_n && !prev_pins.convst_n && busy_cycles > 0)
            begin
                busy_q    = 1'b1;
                remaining = busy_cycles;
            end

            // --------------------
            // serial data
            // --------------------
            // ch1 on the first cs_n fall, ch2 on the one after the gap
            if (!pins.cs_n && prev_pins.cs_n)
            begin
                shift_word = second ? words.ch2 : words.ch1;
                second     = !second;
                sdain_q    = shift_word[SAMPLE_WIDTH_DEF-1];
                shift_word = {shift_word[SAMPLE_WIDTH_DEF-2:0], 1'b0};
            end
            else if (!pins.cs_n && pins.sclk && !prev_pins.sclk)
            begin
                sdain_q    = shift_word[SAMPLE_WIDTH_DEF-1];
                shift_word = {shift_word[SAMPLE_WIDTH_DEF-2:0], 1'b0};
            end
        end
        prev_pins = pins;
    end

endmodule

//--- test/tb_adc_read.sv
`timescale 1ns/1ps

module tb_adc_read
    import adc_read_pkg::*;
();

    localparam int        CLK_PERIOD   = 40;
    localparam int        DRIVE_DELAY  = 2;
    localparam int        RESET_CYCLES = 3;
    localparam int        RANDOM_TESTS = 6;
    localparam adc_pins_t PINS_IDLE    = 3'b111;

    typedef struct packed {
        int          gap;
        int          busy_len;
        adc_sample_t words;
    } test_t;

    logic        lclk_arpel_in = 1'b0;
    logic        lrst_arpel_in = 1'b1;
    logic        adc_enable    = 1'b0;
    logic        busy;
    logic        sdain;
    adc_pins_t   pins;
    adc_sample_t samples;
    logic        done;

    adc_sample_t cur_words     = '0;
    int          cur_busy      = 0;
    int          budget_cycles = 0;
    test_t       tests[$];

    // protocol monitor state
    int          conv_low      = 0;
    int          conv_pulses   = 0;
    int          sclk_pulses   = 0;
    int          windows       = 0;
    int          gap_run       = 0;
    adc_pins_t   mon_prev      = '1;

    always #(CLK_PERIOD / 2) lclk_arpel_in = ~lclk_arpel_in;

    adc_read_top #(
        .SAMPLE_WIDTH  (SAMPLE_WIDTH_DEF),
        .CONVST_CYCLES (CONVST_CYCLES_DEF)
    ) u_dut (
        .lclk_arpel_in (lclk_arpel_in),
        .lrst_arpel_in (lrst_arpel_in),
        .adc_enable    (adc_enable),
        .busy          (busy),
        .sdain         (sdain),
        .pins          (pins),
        .samples       (samples),
        .done          (done)
    );

    adc_serial_model #(
        .DRIVE_DELAY   (DRIVE_DELAY)
    ) u_adc (
        .lclk_arpel_in (lclk_arpel_in),
        .lrst_arpel_in (lrst_arpel_in),
        .pins          (pins),
        .words         (cur_words),
        .busy_cycles   (cur_busy),
        .busy          (busy),
        .sdain         (sdain)
    );

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_pins(input string name, input adc_pins_t expected,
                              input adc_pins_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "pin mismatch");
        end
    endtask

    task automatic check_sample(input string name, input adc_sample_t expected,
                                input adc_sample_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_quiet(input adc_sample_t held);
        check_pins("pins", PINS_IDLE, pins);
        check_flag("done", 1'b0, done);
        check_sample("samples", held, samples);
    endtask

    task automatic next_cycle();
        @(posedge lclk_arpel_in);
        #(DRIVE_DELAY);
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_tests();
        int                          fd;
        int                          n;
        int                          gap;
        int                          busy_len;
        logic [SAMPLE_WIDTH_DEF-1:0] w1;
        logic [SAMPLE_WIDTH_DEF-1:0] w2;
        string                       line;
        test_t                       t;
        fd = $fopen("test/adc_read_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file test/adc_read_tests.txt");
            $display("Test failures found");
            $fatal(1, "missing test file");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                // comment and blank lines never match all four fields
                n = $sscanf(line, "%d %d %h %h", gap, busy_len, w1, w2);
                if (n == 4)
                begin
                    t.gap       = gap;
                    t.busy_len  = busy_len;
                    t.words.ch1 = w1;
                    t.words.ch2 = w2;
                    tests.push_back(t);
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // protocol monitor
    // --------------------
    always @(negedge lclk_arpel_in)
    begin
        if (lrst_arpel_in)
        begin
            conv_low    = 0;
            conv_pulses = 0;
            sclk_pulses = 0;
            windows     = 0;
            gap_run     = 0;
        end
        else
        begin
            if (!pins.convst_n)
            begin
                conv_low = conv_low + 1;
                check_flag("cs_n while convst_n low", 1'b0, pins.cs_n);
            end
            else if (conv_low != 0)
            begin
                check_count("convst_n low cycles", CONVST_CYCLES_DEF, conv_low);
                conv_low    = 0;
                conv_pulses = conv_pulses + 1;
            end
            if (!pins.cs_n && mon_prev.sclk && !pins.sclk)
                sclk_pulses = sclk_pulses + 1;
            // a read window closes on every cs_n rise
            if (pins.cs_n && !mon_prev.cs_n)
            begin
                check_count("sclk low pulses", SAMPLE_WIDTH_DEF, sclk_pulses);
                sclk_pulses = 0;
                gap_run     = 0;
                windows     = windows + 1;
            end
            if (pins.cs_n && windows == 1)
                gap_run = gap_run + 1;
            if (!pins.cs_n && mon_prev.cs_n && windows == 1)
                check_count("cs_n high between windows", 1, gap_run);
            // one convert pulse per finished conversion
            if (windows == 2)
            begin
                check_count("convst_n pulses per conversion", 1, conv_pulses);
                conv_pulses = 0;
                windows     = 0;
            end
        end
        mon_prev = pins;
    end

    // --------------------
    // watchdog
    // --------------------
    initial
    begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge lclk_arpel_in);
        $display("done never arrived within the limit of %0d cycles", budget_cycles);
        $display("Test failures found");
        $fatal(1, "watchdog timeout");
    end

    // --------------------
    // stimulus
    // --------------------
    initial
    begin
        test_t       t;
        adc_sample_t last;
        logic [31:0] rng;
        int          rises;
        int          total;
        logic        prev_cs_n;

        load_tests();
        rng = 32'h63734120;
        repeat (RANDOM_TESTS)
        begin
            rng         = next_random(rng);
            t.words.ch1 = rng[SAMPLE_WIDTH_DEF-1:0];
            rng         = next_random(rng);
            t.words.ch2 = rng[SAMPLE_WIDTH_DEF-1:0];
            rng         = next_random(rng);
            t.gap       = int'(rng[1:0]);
            t.busy_len  = 1 + int'(rng[4:2]);
            tests.push_back(t);
        end

        total = RESET_CYCLES + 10;
        foreach (tests[k])
            total += tests[k].gap + tests[k].busy_len + 4 * SAMPLE_WIDTH_DEF
                     + CONVST_CYCLES_DEF + 20;
        budget_cycles = total;

        repeat (RESET_CYCLES)
        begin
            next_cycle();
            check_quiet('0);
        end
        lrst_arpel_in = 1'b0;
        repeat (2)
        begin
            next_cycle();
            check_quiet('0);
        end

        last = '0;
        foreach (tests[k])
        begin
            t         = tests[k];
            cur_words = t.words;
            cur_busy  = t.busy_len;
            // enable low, nothing may move
            repeat (t.gap)
            begin
                next_cycle();
                check_quiet(last);
            end
            next_cycle();
            adc_enable = 1'b1;
            rises      = 0;
            prev_cs_n  = 1'b1;
            while (rises < 2)
            begin
                next_cycle();
                check_sample("samples during conversion", last, samples);
                if (pins.cs_n && !prev_cs_n)
                    rises = rises + 1;
                prev_cs_n = pins.cs_n;
            end
            // second read window closed, so the sequencer idles after done
            adc_enable = 1'b0;
            while (!done)
            begin
                next_cycle();
            end
            next_cycle();
            check_flag("done after pulse", 1'b0, done);
            check_sample("samples", t.words, samples);
            last = t.words;
        end

        $display("All tests passed!");
        $finish;
    end

endmodule
